/* Bender.yml */
package:
  name: rv32i_subset_cpu

sources:
  - verilog/isaPkg.sv
  - verilog/busMapPkg.sv
  - verilog/fetchUnit.sv
  - verilog/decodeUnit.sv
  - verilog/registerFile.sv
  - verilog/executeUnit.sv
  - verilog/resultUnit.sv
  - verilog/apbHostPort.sv
  - verilog/cpuTop.sv
  - target: test
    files:
      - dv/cpuTb.sv

/* dv/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb import isaPkg::*, busMapPkg::*; ();

  // roughly 70 bus transfers of 3 cycles, 6 resets and under 80 run cycles.
  localparam int cycleLimit = 2000;
  localparam int loopCount  = 5;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [31:0] a0;

  logic [31:0] rngState = 32'h272501de;
  int          cycleCount = 0;
  logic [31:0] progWords [32];
  int          progLen;

  cpuTop u_cpuTop (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .a0(a0)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("CHECKS FAILED");
      $fatal(1, "stopped by the cycle limit");
    end
  end

  // ==========================================================
  // helpers.
  // ==========================================================
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // instruction encoders with fields in RV32I order.
  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opcodeOp};
  endfunction

  function automatic logic [31:0] iType(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sType(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3Word, imm[4:0], opcodeStore};
  endfunction

  function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcodeBranch};
  endfunction

  function automatic logic [31:0] uType(input logic [4:0] rd, input logic [19:0] upper);
    return {upper, rd, opcodeLui};
  endfunction

  function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, opcodeJal};
  endfunction

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first failing check");
    end
  endtask

  // two-cycle APB transfer sampled in the middle of the access phase.
  task automatic apbTransfer(input logic write, input logic [15:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    checkEq("pready", pready, 32'd1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apbWrite(input logic [15:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] ignored;
    apbTransfer(1'b1, addr, data, ignored, err);
  endtask

  task automatic apbRead(input logic [15:0] addr, output logic [31:0] data, output logic err);
    apbTransfer(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic addInstr(input logic [31:0] word);
    progWords[progLen] = word;
    progLen = progLen + 1;
  endtask

  // appends the JAL x0,0 halt, then writes the image from word 0.
  task automatic loadProgram();
    logic err;
    addInstr(jType(5'd0, 21'd0));
    for (int i = 0; i < progLen; i++) begin
      apbWrite(imemBase + 16'(4 * i), progWords[i], err);
      checkEq("pslverr", err, 32'd0);
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
  endtask

  task automatic runFor(input int cycles);
    logic err;
    apbWrite(ctrlAddr, 32'd1 << runBit, err);
    checkEq("pslverr", err, 32'd0);
    repeat (cycles) @(posedge clk);
    apbWrite(ctrlAddr, 32'd0, err);
    checkEq("pslverr", err, 32'd0);
    @(negedge clk);
  endtask

  // ==========================================================
  // directed tests.
  // ==========================================================
  task automatic busAccessTest();
    logic [31:0] words [6];
    logic [31:0] data;
    logic [15:0] addr;
    logic        err;
    checkEq("a0", a0, 32'd0);
    apbRead(ctrlAddr, data, err);
    checkEq("ctrl", data, 32'd0);
    checkEq("pslverr", err, 32'd0);
    // park the core on a halt at word 0.
    apbWrite(imemBase, jType(5'd0, 21'd0), err);
    for (int i = 0; i < 6; i++) begin
      rngState = xorshift(rngState);
      words[i] = rngState;
      addr = imemBase + 16'(160 * i + 4);
      apbWrite(addr, words[i], err);
      checkEq("pslverr", err, 32'd0);
    end
    for (int i = 0; i < 6; i++) begin
      addr = imemBase + 16'(160 * i + 4);
      apbRead(addr, data, err);
      checkEq("imem readback", data, words[i]);
    end
    apbWrite(ctrlAddr, 32'd1 << runBit, err);
    apbRead(ctrlAddr, data, err);
    checkEq("ctrl", data, 32'd1);
    // program writes are refused while the core runs.
    apbWrite(imemBase + 16'd164, ~words[1], err);
    checkEq("pslverr", err, 32'd1);
    apbWrite(ctrlAddr, 32'd0, err);
    apbRead(imemBase + 16'd164, data, err);
    checkEq("imem[41]", data, words[1]);
  endtask

  task automatic arithmeticTest();
    logic [11:0] immA;
    logic [11:0] immB;
    logic [19:0] upper;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] u;
    logic [31:0] diff;
    logic [31:0] expected;
    rngState = xorshift(rngState);
    immA = rngState[11:0];
    rngState = xorshift(rngState);
    immB = rngState[11:0];
    rngState = xorshift(rngState);
    upper = rngState[31:12];
    a = {{20{immA[11]}}, immA};
    b = {{20{immB[11]}}, immB};
    u = {upper, 12'h000};
    diff = a + u - b;
    expected = (((diff & a) | u) ^ diff) + (($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    progLen = 0;
    addInstr(iType(opcodeOpImm, 5'd1, f3AddSub, 5'd0, immA));
    addInstr(iType(opcodeOpImm, 5'd2, f3AddSub, 5'd0, immB));
    addInstr(uType(5'd3, upper));
    addInstr(rType(7'd0, f3AddSub, 5'd4, 5'd1, 5'd3));
    addInstr(rType(f7Sub, f3AddSub, 5'd5, 5'd4, 5'd2));
    addInstr(rType(7'd0, f3And, 5'd6, 5'd5, 5'd1));
    addInstr(rType(7'd0, f3Or, 5'd7, 5'd6, 5'd3));
    addInstr(rType(7'd0, f3Xor, 5'd8, 5'd7, 5'd5));
    addInstr(rType(7'd0, f3Slt, 5'd9, 5'd1, 5'd2));
    addInstr(rType(7'd0, f3AddSub, 5'd10, 5'd8, 5'd9));
    loadProgram();
    applyReset();
    // straight line code, so the static length is the dynamic count.
    runFor(progLen + 4);
    checkEq("a0", a0, expected);
  endtask

  task automatic memoryTest();
    logic [11:0] immA;
    logic [19:0] upper;
    logic [31:0] a;
    logic [31:0] u;
    logic [31:0] data;
    logic        err;
    rngState = xorshift(rngState);
    immA = rngState[11:0];
    rngState = xorshift(rngState);
    upper = rngState[31:12];
    a = {{20{immA[11]}}, immA};
    u = {upper, 12'h000};
    progLen = 0;
    addInstr(iType(opcodeOpImm, 5'd1, f3AddSub, 5'd0, immA));
    addInstr(uType(5'd2, upper));
    addInstr(iType(opcodeOpImm, 5'd5, f3AddSub, 5'd0, 12'd16));
    addInstr(sType(5'd1, 5'd5, 12'd0));
    addInstr(sType(5'd2, 5'd5, 12'd4));
    addInstr(iType(opcodeLoad, 5'd6, f3Word, 5'd5, 12'd0));
    addInstr(iType(opcodeLoad, 5'd7, f3Word, 5'd5, 12'd4));
    addInstr(rType(7'd0, f3AddSub, 5'd10, 5'd6, 5'd7));
    loadProgram();
    applyReset();
    runFor(progLen + 4);
    checkEq("a0", a0, a + u);
    apbRead(dmemBase + 16'd16, data, err);
    checkEq("dmem[4]", data, a);
    apbRead(dmemBase + 16'd20, data, err);
    checkEq("dmem[5]", data, u);
    // the data region is read-only from the bus.
    apbWrite(dmemBase + 16'd16, ~a, err);
    checkEq("pslverr", err, 32'd1);
    apbRead(dmemBase + 16'd16, data, err);
    checkEq("dmem[4]", data, a);
  endtask

  task automatic controlFlowTest();
    progLen = 0;
    addInstr(iType(opcodeOpImm, 5'd10, f3AddSub, 5'd0, 12'd0));
    addInstr(iType(opcodeOpImm, 5'd1, f3AddSub, 5'd0, 12'(loopCount)));
    addInstr(iType(opcodeOpImm, 5'd10, f3AddSub, 5'd10, 12'd1));
    // back to the increment at byte 8.
    addInstr(bType(f3Bne, 5'd10, 5'd1, 13'h1ffc));
    addInstr(bType(f3Beq, 5'd0, 5'd0, 13'd8));
    addInstr(iType(opcodeOpImm, 5'd10, f3AddSub, 5'd10, 12'd100));
    loadProgram();
    applyReset();
    // two setup, two per pass, the BEQ and the halt.
    runFor(2 * loopCount + 4 + 4);
    checkEq("a0", a0, loopCount);
  endtask

  task automatic jumpLinkTest();
    progLen = 0;
    addInstr(iType(opcodeOpImm, 5'd1, f3AddSub, 5'd0, 12'd1));
    addInstr(jType(5'd10, 21'd8));
    addInstr(iType(opcodeOpImm, 5'd10, f3AddSub, 5'd0, 12'h7ff));
    loadProgram();
    applyReset();
    runFor(3 + 4);
    // JAL sits at byte 4.
    checkEq("a0", a0, 32'd8);
  endtask

  task automatic errorResponseTest();
    logic [31:0] data;
    logic        err;
    apbRead(16'h6000, data, err);
    checkEq("pslverr", err, 32'd1);
    apbWrite(16'h1000, 32'hffffffff, err);
    checkEq("pslverr", err, 32'd1);
    // 0x1000 must not alias onto word 0 of the loaded program.
    apbRead(imemBase, data, err);
    checkEq("imem[0]", data, progWords[0]);
    apbWrite(ctrlAddr + 16'd4, 32'd1, err);
    checkEq("pslverr", err, 32'd1);
    apbRead(ctrlAddr, data, err);
    checkEq("ctrl", data, 32'd0);
  endtask

  task automatic resetRerunTest(input logic [31:0] expectA0, input int cycles);
    logic [31:0] data;
    logic        err;
    // leave the core running so the reset has to clear run.
    apbWrite(ctrlAddr, 32'd1 << runBit, err);
    applyReset();
    checkEq("a0", a0, 32'd0);
    apbRead(ctrlAddr, data, err);
    checkEq("ctrl", data, 32'd0);
    runFor(cycles);
    checkEq("a0", a0, expectA0);
  endtask

  initial begin
    reset   <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= 16'h0;
    pwdata  <= 32'h0;
    applyReset();
    busAccessTest();
    arithmeticTest();
    memoryTest();
    controlFlowTest();
    errorResponseTest();
    jumpLinkTest();
    resetRerunTest(32'd8, 3 + 4);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
verilog/isaPkg.sv
verilog/busMapPkg.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/registerFile.sv
verilog/executeUnit.sv
verilog/resultUnit.sv
verilog/apbHostPort.sv
verilog/cpuTop.sv
dv/cpuTb.sv

/* verilog/apbHostPort.sv */
`timescale 1ns/1ps
`default_nettype none

module apbHostPort import busMapPkg::*; #(
  parameter int iMemWords = 256,
  parameter int dMemWords = 256,
  localparam int idxBits = ($clog2(iMemWords) > $clog2(dMemWords)) ?
                           $clog2(iMemWords) : $clog2(dMemWords)
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [15:0]        paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               run,
  output logic               imemWe,
  output logic [idxBits-1:0] memIndex,
  input  logic [31:0]        imemRdata,
  input  logic [31:0]        dmemRdata
);

  logic access;
  logic inImem;
  logic inDmem;
  logic inCtrl;

  // ==========================================================
  // region decode.
  // ==========================================================
  assign access = psel && penable;
  assign inImem = (paddr - imemBase) < regionSpan;
  assign inDmem = (paddr - dmemBase) < regionSpan;
  assign inCtrl = (paddr == ctrlAddr);

  // shared word index into either memory.
  assign memIndex = paddr[idxBits+1:2];

  // the program cannot change under a running core.
  assign imemWe = access && pwrite && inImem && !run;

  always_ff @(posedge clk) begin
    if (reset) begin
      run <= 1'b0;
    end else if (access && pwrite && inCtrl) begin
      run <= pwdata[runBit];
    end
  end

  always_comb begin
    prdata = '0;
    if (inImem) begin
      prdata = imemRdata;
    end else if (inDmem) begin
      prdata = dmemRdata;
    end else if (inCtrl) begin
      prdata[runBit] = run;
    end
  end

  // no wait states.
  assign pready  = 1'b1;
  assign pslverr = access && (!(inImem || inDmem || inCtrl) ||
                              (pwrite && inDmem) ||
                              (pwrite && inImem && run));

endmodule

`default_nettype wire

/* verilog/busMapPkg.sv */
`default_nettype none

package busMapPkg;

  // ==========================================================
  // APB address map, byte addresses.
  // ==========================================================
  localparam logic [15:0] imemBase   = 16'h0000;
  localparam logic [15:0] dmemBase   = 16'h2000;
  localparam logic [15:0] ctrlAddr   = 16'h4000;
  localparam logic [15:0] regionSpan = 16'h1000;

  // control register fields.
  localparam int runBit = 0;

endpackage

`default_nettype wire

/* verilog/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop import isaPkg::*; #(
  parameter int iMemWords = 256,
  parameter int dMemWords = 256
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [15:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic [31:0] a0
);

  localparam int idxBits = ($clog2(iMemWords) > $clog2(dMemWords)) ?
                           $clog2(iMemWords) : $clog2(dMemWords);

  // ==========================================================
  // bus side.
  // ==========================================================
  logic               run;
  logic               imemWe;
  logic [idxBits-1:0] memIndex;
  logic [31:0]        imemRdata;
  logic [31:0]        dmemRdata;

  // ==========================================================
  // core datapath.
  // ==========================================================
  logic [31:0] pc;
  logic [31:0] instr;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic        regWrite;
  logic        aluSrcImm;
  aluOpT       aluOp;
  logic [31:0] imm;
  wbSelT       wbSel;
  logic        memWrite;
  logic        isBranch;
  logic        branchNe;
  logic        isJump;
  logic [31:0] rs1Data;
  logic [31:0] rs2Data;
  logic [31:0] aluResult;
  logic        takeBranch;
  logic [31:0] branchTarget;
  logic [31:0] wbData;

  apbHostPort #(.iMemWords(iMemWords), .dMemWords(dMemWords)) u_apbHostPort (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .run(run), .imemWe(imemWe), .memIndex(memIndex),
    .imemRdata(imemRdata), .dmemRdata(dmemRdata)
  );

  // bus write data goes straight to the instruction memory.
  fetchUnit #(.iMemWords(iMemWords)) u_fetchUnit (
    .clk(clk), .reset(reset), .run(run), .takeBranch(takeBranch),
    .branchTarget(branchTarget), .imemWe(imemWe),
    .memIndex(memIndex[$clog2(iMemWords)-1:0]), .memWdata(pwdata),
    .pc(pc), .instr(instr), .imemRdata(imemRdata)
  );

  decodeUnit u_decodeUnit (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .regWrite(regWrite),
    .aluSrcImm(aluSrcImm), .aluOp(aluOp), .imm(imm), .wbSel(wbSel),
    .memWrite(memWrite), .isBranch(isBranch), .branchNe(branchNe), .isJump(isJump)
  );

  registerFile u_registerFile (
    .clk(clk), .reset(reset), .run(run), .rs1(rs1), .rs2(rs2), .rd(rd),
    .regWrite(regWrite), .wbData(wbData), .rs1Data(rs1Data), .rs2Data(rs2Data),
    .a0(a0)
  );

  executeUnit u_executeUnit (
    .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
    .aluSrcImm(aluSrcImm), .aluOp(aluOp), .isBranch(isBranch),
    .branchNe(branchNe), .isJump(isJump), .aluResult(aluResult),
    .takeBranch(takeBranch), .branchTarget(branchTarget)
  );

  resultUnit #(.dMemWords(dMemWords)) u_resultUnit (
    .clk(clk), .run(run), .memWrite(memWrite), .aluResult(aluResult),
    .rs2Data(rs2Data), .wbSel(wbSel), .pc(pc),
    .memIndex(memIndex[$clog2(dMemWords)-1:0]), .wbData(wbData),
    .dmemRdata(dmemRdata)
  );

endmodule

`default_nettype wire

/* verilog/decodeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeUnit import isaPkg::*; (
  input  logic [31:0] instr,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic        regWrite,
  output logic        aluSrcImm,
  output aluOpT       aluOp,
  output logic [31:0] imm,
  output wbSelT       wbSel,
  output logic        memWrite,
  output logic        isBranch,
  output logic        branchNe,
  output logic        isJump
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  immKindT    immKind;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // ==========================================================
  // control decode.
  // ==========================================================
  always_comb begin
    regWrite  = 1'b0;
    aluSrcImm = 1'b0;
    aluOp     = aluAdd;
    immKind   = immI;
    wbSel     = wbAlu;
    memWrite  = 1'b0;
    isBranch  = 1'b0;
    branchNe  = 1'b0;
    isJump    = 1'b0;
    case (opcode)
      opcodeOp, opcodeOpImm: begin
        aluSrcImm = (opcode == opcodeOpImm);
        regWrite  = 1'b1;
        case (funct3)
          f3AddSub: aluOp = (opcode == opcodeOp && funct7 == f7Sub) ? aluSub : aluAdd;
          f3Slt:    aluOp = aluSlt;
          f3Xor:    aluOp = aluXor;
          f3Or:     aluOp = aluOr;
          f3And:    aluOp = aluAnd;
          default:  regWrite = 1'b0;
        endcase
      end
      opcodeLui: begin
        regWrite  = 1'b1;
        aluSrcImm = 1'b1;
        aluOp     = aluPassB;
        immKind   = immU;
      end
      opcodeLoad: begin
        regWrite  = (funct3 == f3Word);
        aluSrcImm = 1'b1;
        wbSel     = wbMemory;
      end
      opcodeStore: begin
        memWrite  = (funct3 == f3Word);
        aluSrcImm = 1'b1;
        immKind   = immS;
      end
      opcodeBranch: begin
        isBranch = (funct3 == f3Beq) || (funct3 == f3Bne);
        branchNe = (funct3 == f3Bne);
        aluOp    = aluSub;
        immKind  = immB;
      end
      opcodeJal: begin
        regWrite = 1'b1;
        isJump   = 1'b1;
        wbSel    = wbPcPlus4;
        immKind  = immJ;
      end
      // anything else stays a no-op.
      default: ;
    endcase
  end

  // sign-extended immediate.
  always_comb begin
    case (immKind)
      immS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      immB:    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      immU:    imm = {instr[31:12], 12'b0};
      immJ:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

endmodule

`default_nettype wire

/* verilog/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnit import isaPkg::*; (
  input  logic [31:0] pc,
  input  logic [31:0] rs1Data,
  input  logic [31:0] rs2Data,
  input  logic [31:0] imm,
  input  logic        aluSrcImm,
  input  aluOpT       aluOp,
  input  logic        isBranch,
  input  logic        branchNe,
  input  logic        isJump,
  output logic [31:0] aluResult,
  output logic        takeBranch,
  output logic [31:0] branchTarget
);

  logic [31:0] operandB;
  logic        equal;

  assign operandB = aluSrcImm ? imm : rs2Data;

  // ==========================================================
  // ALU.
  // ==========================================================
  always_comb begin
    case (aluOp)
      aluSub:   aluResult = rs1Data - operandB;
      aluAnd:   aluResult = rs1Data & operandB;
      aluOr:    aluResult = rs1Data | operandB;
      aluXor:   aluResult = rs1Data ^ operandB;
      aluSlt:   aluResult = {31'b0, $signed(rs1Data) < $signed(operandB)};
      aluPassB: aluResult = operandB;
      default:  aluResult = rs1Data + operandB;
    endcase
  end

  // branch compare uses the register operands directly.
  assign equal = (rs1Data == rs2Data);

  assign takeBranch   = isJump || (isBranch && (branchNe ? !equal : equal));
  assign branchTarget = pc + imm;

endmodule

`default_nettype wire

/* verilog/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
  parameter int iMemWords = 256
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         run,
  input  logic                         takeBranch,
  input  logic [31:0]                  branchTarget,
  input  logic                         imemWe,
  input  logic [$clog2(iMemWords)-1:0] memIndex,
  input  logic [31:0]                  memWdata,
  output logic [31:0]                  pc,
  output logic [31:0]                  instr,
  output logic [31:0]                  imemRdata
);

  localparam int idxBits = $clog2(iMemWords);

  logic [31:0] imem [iMemWords];

  // pc advances only while the core runs.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (run) begin
      pc <= takeBranch ? branchTarget : pc + 32'd4;
    end
  end

  // bus side write port, guarded by the host port.
  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[memIndex] <= memWdata;
    end
  end

  // word addressed, low pc bits ignored.
  assign instr     = imem[pc[idxBits+1:2]];
  assign imemRdata = imem[memIndex];

endmodule

`default_nettype wire

/* verilog/isaPkg.sv */
`default_nettype none

package isaPkg;

  // ==========================================================
  // major opcodes of the supported RV32I subset.
  // ==========================================================
  localparam logic [6:0] opcodeOp     = 7'b0110011;
  localparam logic [6:0] opcodeOpImm  = 7'b0010011;
  localparam logic [6:0] opcodeLui    = 7'b0110111;
  localparam logic [6:0] opcodeLoad   = 7'b0000011;
  localparam logic [6:0] opcodeStore  = 7'b0100011;
  localparam logic [6:0] opcodeBranch = 7'b1100011;
  localparam logic [6:0] opcodeJal    = 7'b1101111;

  // funct3 values, ALU group first.
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Word   = 3'b010;
  localparam logic [2:0] f3Beq    = 3'b000;
  localparam logic [2:0] f3Bne    = 3'b001;

  // funct7 that turns ADD into SUB.
  localparam logic [6:0] f7Sub = 7'b0100000;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluPassB
  } aluOpT;

  typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immKindT;

  typedef enum logic [1:0] {wbAlu, wbMemory, wbPcPlus4} wbSelT;

endpackage

`default_nettype wire

/* verilog/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        regWrite,
  input  logic [31:0] wbData,
  output logic [31:0] rs1Data,
  output logic [31:0] rs2Data,
  output logic [31:0] a0
);

  logic [31:0] regs [32];

  // x0 is never written, so it stays at its reset value.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (run && regWrite && rd != 5'd0) begin
      regs[rd] <= wbData;
    end
  end

  assign rs1Data = regs[rs1];
  assign rs2Data = regs[rs2];

  // a0 is x10.
  assign a0 = regs[10];

endmodule

`default_nettype wire

/* verilog/resultUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module resultUnit import isaPkg::*; #(
  parameter int dMemWords = 256
) (
  input  logic                         clk,
  input  logic                         run,
  input  logic                         memWrite,
  input  logic [31:0]                  aluResult,
  input  logic [31:0]                  rs2Data,
  input  wbSelT                        wbSel,
  input  logic [31:0]                  pc,
  input  logic [$clog2(dMemWords)-1:0] memIndex,
  output logic [31:0]                  wbData,
  output logic [31:0]                  dmemRdata
);

  localparam int idxBits = $clog2(dMemWords);

  logic [31:0]        dmem [dMemWords];
  logic [idxBits-1:0] coreIndex;
  logic [31:0]        loadData;

  // word address from the ALU sum.
  assign coreIndex = aluResult[idxBits+1:2];

  always_ff @(posedge clk) begin
    if (run && memWrite) begin
      dmem[coreIndex] <= rs2Data;
    end
  end

  assign loadData  = dmem[coreIndex];
  assign dmemRdata = dmem[memIndex];

  // write-back select.
  always_comb begin
    case (wbSel)
      wbMemory:  wbData = loadData;
      wbPcPlus4: wbData = pc + 32'd4;
      default:   wbData = aluResult;
    endcase
  end

endmodule

`default_nettype wire
